// ==== files.f ====
design/mips_pkg.sv
design/instruction_memory.sv
design/controller.sv
design/register_file.sv
design/alu.sv
design/data_memory.sv
design/cpu.sv
verif/cpu_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := cpu_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

  // longest program plus its run with slack for reset and edge alignment
  localparam int max_words      = 32;
  localparam int num_runs       = 7;  // six programs plus the rerun after mid reset
  localparam int timeout_cycles = num_runs * (2 * max_words + 4) + 100;

  logic                         clk;
  logic                         reset;
  logic                         load_en;
  logic [mips_pkg::imem_aw-1:0] load_addr;
  logic [31:0]                  load_data;
  logic [31:0]                  pc;
  logic                         store_valid;
  logic [31:0]                  store_addr;
  logic [31:0]                  store_data;

  logic [31:0] prog[$];                  // program under construction
  logic [31:0] exp_addr[$], exp_data[$]; // model stores
  logic [31:0] got_addr[$], got_data[$]; // seen on the store bus
  logic [31:0] end_pc;                   // self-loop address
  int          cycles = 0;

  cpu dut_i (
    .clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
    .load_data(load_data), .pc(pc), .store_valid(store_valid),
    .store_addr(store_addr), .store_data(store_data)
  );

  always #20 clk = ~clk;

  // each store beat taken on the rising edge that commits it
  always @(posedge clk) begin
    if (store_valid === 1'b1) begin
      got_addr.push_back(store_addr);
      got_data.push_back(store_data);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("run timed out after %0d cycles, pc stuck at %h", cycles, pc);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic check(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic logic [31:0] rtype_word(logic [5:0] fn, int rs, int rt, int rd, int sh);
    return {mips_pkg::op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
  endfunction

  function automatic logic [31:0] itype_word(logic [5:0] op, int rs, int rt, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic logic [31:0] jump_word(logic [5:0] op, int target);
    return {op, 26'(target >> 2)}; // byte target to word field
  endfunction

  task automatic emit(logic [31:0] word);
    prog.push_back(word);
  endtask

  // beats seen while loading or in reset stay queued and fail the count
  task automatic new_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    got_addr.delete();
    got_data.delete();
  endtask

  task automatic expect_store(logic [31:0] addr, logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // full 32-bit constant without lui
  task automatic set_reg(int r, logic [31:0] v);
    emit(itype_word(mips_pkg::op_ori, 0, r, int'(v[31:16])));
    emit(rtype_word(mips_pkg::fn_sll, 0, r, r, 16));
    emit(itype_word(mips_pkg::op_ori, r, r, int'(v[15:0])));
  endtask

  task automatic store_reg(int r, int addr, logic [31:0] v);
    emit(itype_word(mips_pkg::op_sw, 0, r, addr)); // sw r, addr($0)
    expect_store(addr, v);
  endtask

  // append the self loop and load it under reset before release
  task automatic start_program();
    end_pc = prog.size() * 4;
    emit(jump_word(mips_pkg::op_j, end_pc));
    @(negedge clk);
    reset = 1'b1;
    foreach (prog[i]) begin
      load_en   = 1'b1;
      load_addr = 8'(i);
      load_data = prog[i];
      @(negedge clk);
    end
    load_en = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic wait_for_pc(logic [31:0] target);
    while (pc !== target) @(negedge clk);
  endtask

  task automatic compare_stores();
    check("store count", got_addr.size(), exp_addr.size());
    foreach (exp_addr[k]) begin
      check("store_addr", got_addr[k], exp_addr[k]);
      check("store_data", got_data[k], exp_data[k]);
    end
  endtask

  task automatic run_program();
    start_program();
    wait_for_pc(end_pc);
    compare_stores();
  endtask

  task automatic rtype_ops();
    logic [31:0] a, b;
    int          sh;
    a  = $urandom;
    b  = $urandom;
    sh = $urandom_range(31, 1);
    new_program();
    set_reg(1, a);
    set_reg(2, b);
    emit(rtype_word(mips_pkg::fn_add, 1, 2, 3, 0));
    store_reg(3, 'h100, a + b);
    emit(rtype_word(mips_pkg::fn_sub, 1, 2, 4, 0));
    store_reg(4, 'h104, a - b);
    emit(rtype_word(mips_pkg::fn_and, 1, 2, 5, 0));
    store_reg(5, 'h108, a & b);
    emit(rtype_word(mips_pkg::fn_or, 1, 2, 6, 0));
    store_reg(6, 'h10c, a | b);
    emit(rtype_word(mips_pkg::fn_slt, 1, 2, 7, 0)); // signed compare in both orders
    store_reg(7, 'h110, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    emit(rtype_word(mips_pkg::fn_slt, 2, 1, 8, 0));
    store_reg(8, 'h114, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
    emit(rtype_word(mips_pkg::fn_sll, 0, 1, 9, sh)); // shifts rt
    store_reg(9, 'h118, a << sh);
    run_program();
  endtask

  task automatic immediate_ops();
    logic [31:0] v;
    int          imm;
    v   = $urandom;
    imm = 32'h8000 | ($urandom & 32'h7fff); // negative as 16 bits
    new_program();
    set_reg(2, v);
    emit(itype_word(mips_pkg::op_addi, 0, 1, imm));
    store_reg(1, 'h180, {{16{imm[15]}}, imm[15:0]});
    emit(itype_word(mips_pkg::op_addi, 2, 3, imm));
    store_reg(3, 'h184, v + {{16{imm[15]}}, imm[15:0]});
    emit(itype_word(mips_pkg::op_andi, 2, 4, imm)); // logical ops zero extend
    store_reg(4, 'h188, v & {16'h0000, imm[15:0]});
    emit(itype_word(mips_pkg::op_ori, 2, 5, imm));
    store_reg(5, 'h18c, v | {16'h0000, imm[15:0]});
    run_program();
  endtask

  task automatic memory_round_trip();
    logic [31:0] vals[4];
    new_program();
    foreach (vals[k]) begin
      vals[k] = $urandom;
      set_reg(1, vals[k]);
      store_reg(1, 'h200 + 8 * k, vals[k]);
    end
    foreach (vals[k]) begin
      emit(itype_word(mips_pkg::op_lw, 0, 10 + k, 'h200 + 8 * k));
    end
    foreach (vals[k]) begin
      store_reg(10 + k, 'h300 + 4 * k, vals[k]); // copies at new addresses
    end
    run_program();
  endtask

  // branch skips the marker store when taken
  task automatic branch_case(logic [5:0] op, int rt, logic [31:0] a, logic [31:0] b, int k);
    logic taken;
    taken = (op == mips_pkg::op_beq) == (a == b);
    emit(itype_word(op, 1, rt, 1));
    emit(itype_word(mips_pkg::op_sw, 0, 20, 'h400 + 8 * k));
    if (!taken) expect_store('h400 + 8 * k, 'ha);
    store_reg(21, 'h404 + 8 * k, 'hb);
  endtask

  task automatic branch_paths();
    logic [31:0] v;
    v = $urandom;
    new_program();
    emit(itype_word(mips_pkg::op_ori, 0, 20, 'ha));
    emit(itype_word(mips_pkg::op_ori, 0, 21, 'hb));
    set_reg(1, v);
    set_reg(2, v);
    emit(itype_word(mips_pkg::op_addi, 1, 3, 1)); // r3 differs from r1
    branch_case(mips_pkg::op_beq, 2, v, v, 0);
    branch_case(mips_pkg::op_beq, 3, v, v + 1, 1);
    branch_case(mips_pkg::op_bne, 2, v, v, 2);
    branch_case(mips_pkg::op_bne, 3, v, v + 1, 3);
    run_program();
  endtask

  task automatic jump_and_link();
    int sub_pc;
    new_program();
    emit(itype_word(mips_pkg::op_ori, 0, 20, 'h5a));
    emit(jump_word(mips_pkg::op_j, (prog.size() + 2) * 4));
    emit(itype_word(mips_pkg::op_sw, 0, 20, 'h500)); // skipped
    emit(jump_word(mips_pkg::op_j, (prog.size() + 3) * 4)); // over the subroutine
    sub_pc = prog.size() * 4;
    store_reg(31, 'h504, sub_pc + 12); // jal sits at sub_pc + 8
    emit(rtype_word(mips_pkg::fn_jr, 31, 0, 0, 0));
    emit(jump_word(mips_pkg::op_jal, sub_pc));
    store_reg(20, 'h508, 'h5a);
    run_program();
  endtask

  task automatic zero_reg_and_reset();
    logic [31:0] mid_pc;
    new_program();
    emit(itype_word(mips_pkg::op_sw, 0, 5, 'h620));     // r5 fresh out of reset
    emit(itype_word(mips_pkg::op_addi, 0, 0, 'h55));    // dropped
    emit(itype_word(mips_pkg::op_ori, 0, 1, 'h33));
    emit(rtype_word(mips_pkg::fn_add, 1, 1, 0, 0));     // dropped
    emit(itype_word(mips_pkg::op_sw, 0, 0, 'h628));
    emit(itype_word(mips_pkg::op_ori, 0, 5, 'h99));
    mid_pc = prog.size() * 4;
    emit(itype_word(mips_pkg::op_sw, 0, 5, 'h624));     // cut off the first time
    expect_store('h620, 0);
    expect_store('h628, 0);
    expect_store('h620, 0); // rerun sees r5 cleared again
    expect_store('h628, 0);
    expect_store('h624, 'h99);
    start_program();
    wait_for_pc(mid_pc);
    reset = 1'b1;
    @(negedge clk);
    check("pc", pc, 0);
    @(negedge clk);
    reset = 1'b0;
    wait_for_pc(end_pc);
    compare_stores();
  endtask

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    void'($urandom(32'haba4));
    rtype_ops();
    immediate_ops();
    memory_round_trip();
    branch_paths();
    jump_and_link();
    zero_reg_and_reset();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== design/cpu.sv ====
`timescale 1ns/1ps

module cpu (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         load_en,
  input  logic [mips_pkg::imem_aw-1:0] load_addr,
  input  logic [31:0]                  load_data,
  output logic [31:0]                  pc,
  output logic                         store_valid,
  output logic [31:0]                  store_addr,
  output logic [31:0]                  store_data
);

  mips_pkg::instr_t  instr;
  mips_pkg::pc_sel_t pc_sel;
  mips_pkg::alu_op_t alu_op;
  mips_pkg::wa_sel_t wa_sel;
  mips_pkg::wb_sel_t wb_sel;
  logic              branch_ne, alu_src_imm, zero_ext, reg_wen, mem_wen;
  logic              dm_wen;                 // mem_wen held off in reset
  logic [31:0]       pc_plus4, pc_target, pc_jadr, pc_next;
  logic [31:0]       imm_sext, imm_ext;
  logic [31:0]       rdata_a, rdata_b, operand_b, alu_result, dm_rdata;
  logic [31:0]       rf_wdata;
  logic [4:0]        rf_wa;
  logic              alu_zero, take_branch;

  instruction_memory imem_i (
    .clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
    .load_data(load_data), .addr(pc), .instr(instr)
  );

  controller ctrl_i (
    .opcode(instr.r.opcode), .funct(instr.r.funct), .pc_sel(pc_sel),
    .branch_ne(branch_ne), .alu_op(alu_op), .alu_src_imm(alu_src_imm),
    .zero_ext(zero_ext), .reg_wen(reg_wen), .wa_sel(wa_sel), .wb_sel(wb_sel),
    .mem_wen(mem_wen)
  );

  // immediate, sign extended for branches always
  assign imm_sext = {{16{instr.i.imm[15]}}, instr.i.imm};
  assign imm_ext  = zero_ext ? {16'd0, instr.i.imm} : imm_sext;
  assign operand_b = alu_src_imm ? imm_ext : rdata_b;

  always_comb begin
    case (wa_sel)
      mips_pkg::wa_rd: rf_wa = instr.r.rd;
      mips_pkg::wa_ra: rf_wa = mips_pkg::link_reg;
      default:         rf_wa = instr.r.rt;
    endcase
    case (wb_sel)
      mips_pkg::wb_mem:  rf_wdata = dm_rdata;
      mips_pkg::wb_link: rf_wdata = pc_plus4; // jal return address
      default:           rf_wdata = alu_result;
    endcase
  end

  register_file rf_i (
    .clk(clk), .reset(reset), .ra(instr.r.rs), .rb(instr.r.rt), .wa(rf_wa),
    .wen(reg_wen), .wdata(rf_wdata), .rdata_a(rdata_a), .rdata_b(rdata_b)
  );

  alu alu_i (
    .a(rdata_a), .b(operand_b), .shamt(instr.r.shamt), .op(alu_op),
    .result(alu_result), .zero(alu_zero)
  );

  assign dm_wen = mem_wen & ~reset; // no stores while loading

  data_memory dmem_i (
    .clk(clk), .addr(alu_result[mips_pkg::dmem_aw+1:2]), .wen(dm_wen),
    .wdata(rdata_b), .rdata(dm_rdata)
  );

  // store bus mirrors the dmem write port
  assign store_valid = dm_wen;
  assign store_addr  = alu_result; // byte address
  assign store_data  = rdata_b;

  // next pc
  assign pc_plus4    = pc + 32'd4;
  assign pc_target   = pc_plus4 + {imm_sext[29:0], 2'b00};
  assign pc_jadr     = {pc_plus4[31:28], instr.j.jadr, 2'b00};
  assign take_branch = alu_zero ^ branch_ne; // beq on zero, bne on nonzero

  always_comb begin
    case (pc_sel)
      mips_pkg::pc_branch: pc_next = take_branch ? pc_target : pc_plus4;
      mips_pkg::pc_jump:   pc_next = pc_jadr;
      mips_pkg::pc_reg:    pc_next = rdata_a; // jr rs
      default:             pc_next = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// ==== design/data_memory.sv ====
`timescale 1ns/1ps

module data_memory (
  input  logic                         clk,
  input  logic [mips_pkg::dmem_aw-1:0] addr,  // word address
  input  logic                         wen,
  input  logic [31:0]                  wdata,
  output logic [31:0]                  rdata
);

  logic [31:0] mem [mips_pkg::dmem_depth];

  // store commits on the edge closing the sw cycle
  always_ff @(posedge clk) begin
    if (wen) begin
      mem[addr] <= wdata;
    end
  end

  assign rdata = mem[addr]; // lw sees it in the same cycle

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  logic [31:0]       a,
  input  logic [31:0]       b,
  input  logic [4:0]        shamt,
  input  mips_pkg::alu_op_t op,
  output logic [31:0]       result,
  output logic              zero
);

  logic [31:0] diff;
  logic        lt;

  assign diff = a - b;

  // signed less-than from the subtraction
  // overflow flips the sign bit, so fall back on operand signs when they differ
  assign lt = (a[31] != b[31]) ? a[31] : diff[31];

  always_comb begin
    case (op)
      mips_pkg::alu_add: result = a + b;
      mips_pkg::alu_sub: result = diff;
      mips_pkg::alu_and: result = a & b;
      mips_pkg::alu_or:  result = a | b;
      mips_pkg::alu_slt: result = {31'd0, lt};
      mips_pkg::alu_sll: result = b << shamt; // rt shifted, rs unused
      default:           result = '0;
    endcase
  end

  assign zero = (result == 32'd0); // beq/bne look at this after sub

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  ra,      // rs
  input  logic [4:0]  rb,      // rt
  input  logic [4:0]  wa,
  input  logic        wen,
  input  logic [31:0] wdata,
  output logic [31:0] rdata_a,
  output logic [31:0] rdata_b
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (wa != 5'd0)) begin
      regs[wa] <= wdata; // $0 writes dropped
    end
  end

  // reads are combinational, $0 hardwired
  assign rdata_a = (ra == 5'd0) ? 32'd0 : regs[ra];
  assign rdata_b = (rb == 5'd0) ? 32'd0 : regs[rb];

endmodule

// ==== design/controller.sv ====
`timescale 1ns/1ps

module controller (
  input  logic [5:0]        opcode,
  input  logic [5:0]        funct,
  output mips_pkg::pc_sel_t pc_sel,
  output logic              branch_ne,    // bne rather than beq
  output mips_pkg::alu_op_t alu_op,
  output logic              alu_src_imm,  // operand b from immediate
  output logic              zero_ext,     // andi / ori
  output logic              reg_wen,
  output mips_pkg::wa_sel_t wa_sel,
  output mips_pkg::wb_sel_t wb_sel,
  output logic              mem_wen
);

  always_comb begin
    // nop unless decoded below
    pc_sel      = mips_pkg::pc_plus4;
    branch_ne   = 1'b0;
    alu_op      = mips_pkg::alu_add;
    alu_src_imm = 1'b0;
    zero_ext    = 1'b0;
    reg_wen     = 1'b0;
    wa_sel      = mips_pkg::wa_rt;
    wb_sel      = mips_pkg::wb_alu;
    mem_wen     = 1'b0;

    case (opcode)
      mips_pkg::op_rtype: begin
        wa_sel  = mips_pkg::wa_rd;
        reg_wen = 1'b1;
        case (funct)
          mips_pkg::fn_add: alu_op = mips_pkg::alu_add;
          mips_pkg::fn_sub: alu_op = mips_pkg::alu_sub;
          mips_pkg::fn_and: alu_op = mips_pkg::alu_and;
          mips_pkg::fn_or:  alu_op = mips_pkg::alu_or;
          mips_pkg::fn_slt: alu_op = mips_pkg::alu_slt;
          mips_pkg::fn_sll: alu_op = mips_pkg::alu_sll;
          mips_pkg::fn_jr: begin
            pc_sel  = mips_pkg::pc_reg;
            reg_wen = 1'b0; // no writeback
          end
          default: reg_wen = 1'b0; // unknown funct decodes as nop
        endcase
      end
      mips_pkg::op_addi: begin
        alu_src_imm = 1'b1;
        reg_wen     = 1'b1;
      end
      mips_pkg::op_andi: begin
        alu_op      = mips_pkg::alu_and;
        alu_src_imm = 1'b1;
        zero_ext    = 1'b1;
        reg_wen     = 1'b1;
      end
      mips_pkg::op_ori: begin
        alu_op      = mips_pkg::alu_or;
        alu_src_imm = 1'b1;
        zero_ext    = 1'b1;
        reg_wen     = 1'b1;
      end
      mips_pkg::op_lw: begin
        alu_src_imm = 1'b1; // base + offset
        reg_wen     = 1'b1;
        wb_sel      = mips_pkg::wb_mem;
      end
      mips_pkg::op_sw: begin
        alu_src_imm = 1'b1;
        mem_wen     = 1'b1;
      end
      mips_pkg::op_beq, mips_pkg::op_bne: begin
        pc_sel    = mips_pkg::pc_branch;
        alu_op    = mips_pkg::alu_sub;         // compare via zero flag
        branch_ne = (opcode == mips_pkg::op_bne);
      end
      mips_pkg::op_j: pc_sel = mips_pkg::pc_jump;
      mips_pkg::op_jal: begin
        pc_sel  = mips_pkg::pc_jump;
        reg_wen = 1'b1;
        wa_sel  = mips_pkg::wa_ra;   // $31
        wb_sel  = mips_pkg::wb_link; // pc+4
      end
      default: ; // unknown opcode stays a nop
    endcase
  end

endmodule

// ==== design/instruction_memory.sv ====
`timescale 1ns/1ps

module instruction_memory (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         load_en,    // loader strobe
  input  logic [mips_pkg::imem_aw-1:0] load_addr,  // word address
  input  logic [31:0]                  load_data,
  input  logic [31:0]                  addr,       // byte address from pc
  output mips_pkg::instr_t             instr
);

  logic [31:0] mem [mips_pkg::imem_depth];

  // program load, only while the core is held in reset
  always_ff @(posedge clk) begin
    if (reset && load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // fetch is combinational
  always_comb begin
    if (addr[31:mips_pkg::imem_aw+2] != '0) begin
      instr = '0; // past the array, all zero decodes as sll $0 nop
    end else begin
      instr = mem[addr[mips_pkg::imem_aw+1:2]]; // drop byte offset
    end
  end

endmodule

// ==== design/mips_pkg.sv ====
package mips_pkg;

  // memory geometry, in 32-bit words
  localparam int imem_depth = 256;
  localparam int dmem_depth = 256;
  localparam int imem_aw    = 8;   // word address bits
  localparam int dmem_aw    = 8;

  localparam logic [4:0] link_reg = 5'd31; // jal target register

  // primary opcodes
  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_j     = 6'h02;
  localparam logic [5:0] op_jal   = 6'h03;
  localparam logic [5:0] op_beq   = 6'h04;
  localparam logic [5:0] op_bne   = 6'h05;
  localparam logic [5:0] op_addi  = 6'h08;
  localparam logic [5:0] op_andi  = 6'h0c;
  localparam logic [5:0] op_ori   = 6'h0d;
  localparam logic [5:0] op_lw    = 6'h23;
  localparam logic [5:0] op_sw    = 6'h2b;

  // funct field, r-type only
  localparam logic [5:0] fn_sll = 6'h00;
  localparam logic [5:0] fn_jr  = 6'h08;
  localparam logic [5:0] fn_add = 6'h20;
  localparam logic [5:0] fn_sub = 6'h22;
  localparam logic [5:0] fn_and = 6'h24;
  localparam logic [5:0] fn_or  = 6'h25;
  localparam logic [5:0] fn_slt = 6'h2a;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] jadr;   // word target within the current 256MB region
  } j_fmt_t;

  // one fetched word, three ways to read it
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    j_fmt_t j;
  } instr_t;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_slt = 3'd4,
    alu_sll = 3'd5
  } alu_op_t;

  typedef enum logic [1:0] {pc_plus4, pc_branch, pc_jump, pc_reg} pc_sel_t;
  typedef enum logic [1:0] {wb_alu, wb_mem, wb_link} wb_sel_t;
  typedef enum logic [1:0] {wa_rt, wa_rd, wa_ra} wa_sel_t;

endpackage
